/* hdl/ext_mem_pkg.sv */
package ext_mem_pkg;

   // Native bus geometry
   localparam int ADDR_W     = 16;
   localparam int DATA_W     = 32;
   localparam int STRB_W     = DATA_W / 8;
   localparam int BYTE_OFF_W = 2;    // Byte lanes within a word

   // Byte address, low two bits are ignored by the caches
   typedef logic [ADDR_W-1:0] addr_t;

   // One bus word
   typedef logic [DATA_W-1:0] data_t;

   // Byte enables, all zeros for a read
   typedef logic [STRB_W-1:0] strb_t;

   // Request toward a slave
   // Shared by the cache front ends, the back ends and the memory port
   typedef struct packed {
      logic  valid;   // Held until ready
      addr_t addr;
      data_t wdata;
      strb_t wstrb;
   } mem_req_t;

   // Response back to a master
   typedef struct packed {
      data_t rdata;
      logic  ready;   // One cycle, ends the access
   } mem_resp_t;

   // Byte lane merge for partial writes
   function automatic data_t merge_bytes(data_t old_word, data_t new_word, strb_t strb);
      data_t result;
      result = old_word;
      for (int b = 0; b < STRB_W; b++) begin
         if (strb[b])
            result[8*b +: 8] = new_word[8*b +: 8];
      end
      return result;
   endfunction

endpackage

/* hdl/l1_cache.sv */
`timescale 1ns/1ps

module l1_cache
   import ext_mem_pkg::*;
#(
   parameter int LINE_OFF_W = 4,
   parameter bit WRITE_EN   = 1'b0    // 1 for the write-through data cache
) (
   input  logic      clk,
   input  logic      rst,

   // Requester side
   input  mem_req_t  fe_req,
   output mem_resp_t fe_resp,

   // Memory side
   output mem_req_t  be_req,
   input  mem_resp_t be_resp,

   input  logic      inv
);

   localparam int LINES = 1 << LINE_OFF_W;
   localparam int TAG_W = ADDR_W - BYTE_OFF_W - LINE_OFF_W;

   typedef logic [LINE_OFF_W-1:0] idx_t;
   typedef logic [TAG_W-1:0]      tag_t;

   typedef enum logic [2:0] {
      S_IDLE,
      S_LOOKUP,
      S_FETCH,
      S_WRITE,
      S_RESPOND
   } state_t;

   state_t state;
   state_t state_nxt;

   // Captured request
   addr_t req_addr;
   data_t req_wdata;
   strb_t req_wstrb;
   data_t rdata_q;   // Word returned by memory

   // Line storage
   logic [LINES-1:0] line_valid;
   tag_t             tag_mem  [LINES];
   data_t            data_mem [LINES];

   idx_t idx;
   tag_t tag;
   logic hit;
   logic is_write;
   logic be_done;
   logic be_wait;
   logic inv_pend;   // Invalidate waiting for the back end
   logic inv_all;

   assign idx      = req_addr[BYTE_OFF_W +: LINE_OFF_W];
   assign tag      = req_addr[ADDR_W-1 -: TAG_W];
   assign hit      = line_valid[idx] && (tag_mem[idx] == tag);
   assign is_write = WRITE_EN && (req_wstrb != '0);   // Read-only cache ignores strobes

   assign be_done = be_req.valid && be_resp.ready;
   assign be_wait = be_req.valid && !be_resp.ready;

   // No clear while a fill or write is still outstanding
   assign inv_all = (inv || inv_pend) && !be_wait;

   always_comb begin
      state_nxt = state;
      case (state)
         S_IDLE: begin
            if (fe_req.valid)
               state_nxt = S_LOOKUP;
         end
         S_LOOKUP: begin
            if (is_write)
               state_nxt = S_WRITE;   // Always goes to memory
            else if (hit)
               state_nxt = S_IDLE;    // Answered this cycle
            else
               state_nxt = S_FETCH;
         end
         S_FETCH: begin
            if (be_resp.ready)
               state_nxt = S_RESPOND;
         end
         S_WRITE: begin
            if (be_resp.ready)
               state_nxt = S_RESPOND;
         end
         S_RESPOND: state_nxt = S_IDLE;
         default:   state_nxt = S_IDLE;
      endcase
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state      <= S_IDLE;
         inv_pend   <= 1'b0;
         line_valid <= '0;
      end else begin
         state    <= state_nxt;
         inv_pend <= be_wait && (inv || inv_pend);
         if (state == S_FETCH && be_resp.ready)
            line_valid[idx] <= 1'b1;
         // Clear after the fill so that a late invalidate wins
         if (inv_all)
            line_valid <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && fe_req.valid) begin
         req_addr  <= fe_req.addr;
         req_wdata <= fe_req.wdata;
         req_wstrb <= fe_req.wstrb;
      end
      if (be_done)
         rdata_q <= be_resp.rdata;
      if (state == S_FETCH && be_resp.ready) begin
         tag_mem[idx]  <= tag;
         data_mem[idx] <= be_resp.rdata;
      end
      // Write hit updates the line, a miss does not allocate
      if (state == S_WRITE && be_resp.ready && hit)
         data_mem[idx] <= merge_bytes(data_mem[idx], req_wdata, req_wstrb);
   end

   assign be_req.valid = (state == S_FETCH) || (state == S_WRITE);
   assign be_req.addr  = req_addr;
   assign be_req.wdata = req_wdata;
   assign be_req.wstrb = (state == S_WRITE) ? req_wstrb : '0;   // Fetch is a read

   assign fe_resp.ready = (state == S_LOOKUP && !is_write && hit) || (state == S_RESPOND);
   assign fe_resp.rdata = (state == S_LOOKUP) ? data_mem[idx] : rdata_q;

endmodule

/* hdl/bus_merge.sv */
`timescale 1ns/1ps

module bus_merge
   import ext_mem_pkg::*;
(
   input  logic      clk,
   input  logic      rst,

   // Instruction cache back end
   input  mem_req_t  m0_req,
   output mem_resp_t m0_resp,

   // Data cache back end
   input  mem_req_t  m1_req,
   output mem_resp_t m1_resp,

   // Memory port
   output mem_req_t  s_req,
   input  mem_resp_t s_resp
);

   logic busy;    // Access open on the memory port
   logic gnt_q;   // Locked winner, 1 selects m1
   logic gnt;     // Grant in effect this cycle

   // Fixed priority when idle, data cache first
   assign gnt = busy ? gnt_q : m1_req.valid;

   assign s_req = gnt ? m1_req : m0_req;

   // Lock the grant while the memory holds off ready
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         busy  <= 1'b0;
         gnt_q <= 1'b0;
      end else begin
         if (s_req.valid && !s_resp.ready) begin
            busy  <= 1'b1;
            gnt_q <= gnt;
         end else if (s_resp.ready) begin
            busy  <= 1'b0;
         end
      end
   end

   // Only the granted master sees the response
   always_comb begin
      m0_resp = '0;
      m1_resp = '0;
      if (gnt) begin
         m1_resp.rdata = s_resp.rdata;
         m1_resp.ready = s_resp.ready;
      end else begin
         m0_resp.rdata = s_resp.rdata;
         m0_resp.ready = s_resp.ready;
      end
   end

endmodule

/* hdl/ext_mem.sv */
`timescale 1ns/1ps

module ext_mem
   import ext_mem_pkg::*;
#(
   parameter int LINE_OFF_W = 4   // Lines per cache as a power of two
) (
   input  logic      clk,
   input  logic      rst,

   // Instruction fetch port
   input  mem_req_t  i_req,
   output mem_resp_t i_resp,

   // Load and store port
   input  mem_req_t  d_req,
   output mem_resp_t d_resp,

   input  logic      inv,         // Clears both caches

   // Native memory port
   output mem_req_t  mem_req,
   input  mem_resp_t mem_resp
);

   // Cache back ends into the merge
   mem_req_t  icache_be_req;
   mem_resp_t icache_be_resp;
   mem_req_t  dcache_be_req;
   mem_resp_t dcache_be_resp;

   l1_cache #(
      .LINE_OFF_W (LINE_OFF_W),
      .WRITE_EN   (1'b0)          // Read only
   ) u_icache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (i_req),
      .fe_resp (i_resp),
      .be_req  (icache_be_req),
      .be_resp (icache_be_resp),
      .inv     (inv)
   );

   l1_cache #(
      .LINE_OFF_W (LINE_OFF_W),
      .WRITE_EN   (1'b1)          // Write through
   ) u_dcache (
      .clk     (clk),
      .rst     (rst),
      .fe_req  (d_req),
      .fe_resp (d_resp),
      .be_req  (dcache_be_req),
      .be_resp (dcache_be_resp),
      .inv     (inv)
   );

   // Data cache on m1 for priority
   bus_merge u_merge (
      .clk     (clk),
      .rst     (rst),
      .m0_req  (icache_be_req),
      .m0_resp (icache_be_resp),
      .m1_req  (dcache_be_req),
      .m1_resp (dcache_be_resp),
      .s_req   (mem_req),
      .s_resp  (mem_resp)
   );

endmodule

/* test/ext_mem_assertions.sv */
`timescale 1ns/1ps

module ext_mem_assertions
   import ext_mem_pkg::*;
(
   input logic      clk,
   input logic      rst,
   input mem_req_t  m0_req,
   input mem_req_t  m1_req,
   input mem_resp_t m0_resp,
   input mem_resp_t m1_resp,
   input mem_req_t  s_req,
   input mem_resp_t s_resp,
   input logic      busy
);

   logic m1_waiting;   // Data cache asked while the port was idle

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         m1_waiting <= 1'b0;
      else if (m1_resp.ready)
         m1_waiting <= 1'b0;
      else if (!busy && m1_req.valid)
         m1_waiting <= 1'b1;
   end

   // Memory side request frozen until ready
   a_req_hold: assert property (@(posedge clk) disable iff (rst)
      (s_req.valid && !s_resp.ready) |=> $stable(s_req))
      else $error("Memory request changed while waiting for ready");

   // Ready goes only to the master whose request the memory served
   a_m0_granted: assert property (@(posedge clk) disable iff (rst)
      m0_resp.ready |-> (m0_req.valid && $past(s_req) == $past(m0_req)))
      else $error("Instruction cache got ready without a grant");

   a_m1_granted: assert property (@(posedge clk) disable iff (rst)
      m1_resp.ready |-> (m1_req.valid && $past(s_req) == $past(m1_req)))
      else $error("Data cache got ready without a grant");

   // Data cache wins an idle arbitration
   a_m1_priority: assert property (@(posedge clk) disable iff (rst)
      m1_waiting |-> !m0_resp.ready)
      else $error("Instruction cache granted over a waiting data cache");

endmodule

bind bus_merge ext_mem_assertions u_merge_assertions (
   .clk     (clk),
   .rst     (rst),
   .m0_req  (m0_req),
   .m1_req  (m1_req),
   .m0_resp (m0_resp),
   .m1_resp (m1_resp),
   .s_req   (s_req),
   .s_resp  (s_resp),
   .busy    (busy)
);

/* test/tb_ext_mem.sv */
`timescale 1ns/1ps

module tb_ext_mem
   import ext_mem_pkg::*;
();

   localparam int    RESET_CYCLES    = 10;
   localparam int    CYCLES_PER_CASE = 40;
   localparam int    MEM_WORDS       = 1024;
   localparam int    MEM_LATENCY     = 3;    // Cycles from valid to ready
   localparam int    MAX_CASES       = 64;
   localparam string CASE_FILE       = "test/ext_mem_cases.txt";

   logic      clk;
   logic      rst;
   logic      inv;
   mem_req_t  i_req;
   mem_req_t  d_req;
   mem_req_t  mem_req;
   mem_resp_t i_resp;
   mem_resp_t d_resp;
   mem_resp_t mem_resp = '0;

   // Memory model state
   data_t      mem [MEM_WORDS];
   logic [9:0] mem_word;
   int         mem_wait;
   int         access_cnt;

   // Case table
   string case_name  [MAX_CASES];
   string case_port  [MAX_CASES];
   string case_op    [MAX_CASES];
   addr_t case_addr  [MAX_CASES];
   data_t case_wdata [MAX_CASES];
   strb_t case_strb  [MAX_CASES];
   data_t case_exp   [MAX_CASES];
   int    case_acc   [MAX_CASES];
   int    num_cases     = 0;

   int cycle_cnt     = 0;
   int timeout_limit = 1000;   // Until the case count is known
   int fail_cnt      = 0;

   ext_mem #(
      .LINE_OFF_W (4)
   ) u_ext_mem (
      .clk      (clk),
      .rst      (rst),
      .i_req    (i_req),
      .i_resp   (i_resp),
      .d_req    (d_req),
      .d_resp   (d_resp),
      .inv      (inv),
      .mem_req  (mem_req),
      .mem_resp (mem_resp)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > timeout_limit) begin
         $display("Timeout after %0d cycles, the DUT stopped answering", cycle_cnt);
         $display("Done: errors found");
         $finish;
      end
   end

   // Word memory, ready a fixed number of cycles after valid
   always @(posedge clk) begin
      if (rst) begin
         for (int w = 0; w < MEM_WORDS; w++)
            mem[w] = 32'hA5A50000 ^ w;
         mem_resp   <= '0;
         mem_wait   <= 0;
         access_cnt <= 0;
      end else begin
         mem_resp.ready <= 1'b0;
         if (mem_req.valid && !mem_resp.ready) begin
            if (mem_wait == MEM_LATENCY - 1) begin
               mem_word = mem_req.addr[11:2];
               mem_resp.rdata <= mem[mem_word];
               for (int b = 0; b < 4; b++) begin
                  if (mem_req.wstrb[b])
                     mem[mem_word][8*b +: 8] = mem_req.wdata[8*b +: 8];
               end
               mem_resp.ready <= 1'b1;
               mem_wait       <= 0;
               access_cnt     <= access_cnt + 1;
            end else begin
               mem_wait <= mem_wait + 1;
            end
         end
      end
   end

   task automatic load_cases();
      int    fd;
      int    n;
      string line;
      string name;
      string port;
      string op;
      addr_t addr;
      data_t wdata;
      strb_t strb;
      data_t exp;
      int    acc;
      fd = $fopen(CASE_FILE, "r");
      if (fd == 0) begin
         $display("Cannot open the case file %s", CASE_FILE);
         return;
      end
      while ($fgets(line, fd) != 0) begin
         n = $sscanf(line, "%s %s %s %h %h %h %h %d",
                     name, port, op, addr, wdata, strb, exp, acc);
         if (n == 8 && num_cases < MAX_CASES) begin   // Column header lines fall out here
            case_name[num_cases]  = name;
            case_port[num_cases]  = port;
            case_op[num_cases]    = op;
            case_addr[num_cases]  = addr;
            case_wdata[num_cases] = wdata;
            case_strb[num_cases]  = strb;
            case_exp[num_cases]   = exp;
            case_acc[num_cases]   = acc;
            num_cases++;
         end
      end
      $fclose(fd);
      if (num_cases == 0)
         $display("No cases found in %s", CASE_FILE);
   endtask

   // One front-end access, held until ready
   task automatic access_port(input bit on_d, input mem_req_t req, output data_t rdata);
      @(posedge clk);
      if (on_d)
         d_req <= req;
      else
         i_req <= req;
      do
         @(negedge clk);
      while (!(on_d ? d_resp.ready : i_resp.ready));
      rdata = on_d ? d_resp.rdata : i_resp.rdata;
      @(posedge clk);
      if (on_d)
         d_req <= '0;
      else
         i_req <= '0;
   endtask

   task automatic pulse_inv();
      @(posedge clk);
      inv <= 1'b1;
      @(posedge clk);
      inv <= 1'b0;
   endtask

   task automatic run_case(input int k);
      mem_req_t req;
      data_t    d_rdata;
      data_t    i_rdata;
      int       acc_start;
      int       acc_used;
      int       errs;
      req.valid = 1'b1;
      req.addr  = case_addr[k];
      req.wdata = case_wdata[k];
      req.wstrb = case_strb[k];
      d_rdata   = '0;
      i_rdata   = '0;
      errs      = 0;
      acc_start = access_cnt;
      if (case_op[k] == "inv") begin
         pulse_inv();
      end else if (case_port[k] == "b") begin
         fork
            access_port(1'b1, req, d_rdata);
            access_port(1'b0, req, i_rdata);
         join
      end else if (case_port[k] == "d") begin
         access_port(1'b1, req, d_rdata);
      end else begin
         access_port(1'b0, req, i_rdata);
      end
      acc_used = access_cnt - acc_start;   // Memory ready comes before the front-end ready
      if (case_op[k] == "read" && case_port[k] != "i" && d_rdata !== case_exp[k]) begin
         $display("ERR %s d rdata expected %h actual %h", case_name[k], case_exp[k], d_rdata);
         errs++;
      end
      if (case_op[k] == "read" && case_port[k] != "d" && i_rdata !== case_exp[k]) begin
         $display("ERR %s i rdata expected %h actual %h", case_name[k], case_exp[k], i_rdata);
         errs++;
      end
      if (acc_used != case_acc[k]) begin
         $display("ERR %s accesses expected %0d actual %0d", case_name[k], case_acc[k], acc_used);
         errs++;
      end
      if (errs == 0) begin
         $display("ok   %s (%0d accesses)", case_name[k], acc_used);
      end else begin
         $display("fail %s with %0d mismatches", case_name[k], errs);
         fail_cnt++;
      end
   endtask

   initial begin
      rst   <= 1'b1;
      inv   <= 1'b0;
      i_req <= '0;
      d_req <= '0;
      load_cases();
      timeout_limit = RESET_CYCLES + CYCLES_PER_CASE * (num_cases + 1);
      repeat (RESET_CYCLES) @(posedge clk);
      rst <= 1'b0;
      for (int k = 0; k < num_cases; k++)
         run_case(k);
      $display("Tests %0d, passed %0d, failed %0d", num_cases, num_cases - fail_cnt, fail_cnt);
      if (fail_cnt == 0 && num_cases > 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule

/* test/ext_mem_cases.txt */
# name port op addr wdata wstrb exp_rdata exp_accesses
# port is i, d or b for both at once, and the four middle fields are hex
d_rd_miss       d read  0100 00000000 0 a5a50040 1
d_rd_hit        d read  0100 00000000 0 a5a50040 0
i_rd_miss       i read  0104 00000000 0 a5a50041 1
i_rd_hit        i read  0104 00000000 0 a5a50041 0
d_wr_hit        d write 0100 12345678 3 00000000 1
d_rd_merged     d read  0100 00000000 0 a5a55678 0
d_wr_miss       d write 0208 cafef00d f 00000000 1
d_rd_new        d read  0208 00000000 0 cafef00d 1
i_rd_written    i read  0208 00000000 0 cafef00d 1
d_wr_upper      d write 030c 11223344 c 00000000 1
i_rd_upper      i read  030c 00000000 0 112200c3 1
b_rd_miss       b read  0014 00000000 0 a5a50005 2
b_rd_hit        b read  0014 00000000 0 a5a50005 0
inv_both        b inv   0000 00000000 0 00000000 0
d_rd_after_inv  d read  0100 00000000 0 a5a55678 1
i_rd_after_inv  i read  0104 00000000 0 a5a50041 1
b_rd_after_inv  b read  0014 00000000 0 a5a50005 2
d_rd_tag_a      d read  0018 00000000 0 a5a50006 1
d_rd_tag_b      d read  0418 00000000 0 a5a50106 1
d_rd_tag_a2     d read  0018 00000000 0 a5a50006 1
i_rd_tag_a      i read  0020 00000000 0 a5a50008 1
i_rd_tag_b      i read  0820 00000000 0 a5a50208 1
i_rd_tag_a2     i read  0020 00000000 0 a5a50008 1
i_rd_tag_a3     i read  0020 00000000 0 a5a50008 0

/* compile.f */
hdl/ext_mem_pkg.sv
hdl/l1_cache.sv
hdl/bus_merge.sv
hdl/ext_mem.sv
test/ext_mem_assertions.sv
test/tb_ext_mem.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ext_mem
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Done: no errors

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
